//--- logic/obj_pkg.sv
/*
 * Shared definitions for the sprite line renderer
 * Field widths, object table byte offsets, attribute byte layout
 * and the transparent colour code
 */

package obj_pkg;

    typedef logic [9:0]  obj_code_t;   // Tile code
    typedef logic [3:0]  obj_row_t;    // Row inside a 16-row tile
    typedef logic [8:0]  obj_pos_t;    // X position, bit 8 is off screen
    typedef logic [3:0]  obj_color_t;
    typedef logic [1:0]  obj_pal_t;
    typedef logic [7:0]  obj_line_t;
    typedef logic [3:0]  obj_step_t;   // Pixel step within an object
    typedef logic [15:0] rom_addr_t;   // {code, row, column group}
    typedef logic [15:0] rom_word_t;   // {z, y, x, w} planes
    typedef logic [7:0]  obj_byte_t;

    // Never written to the line buffer, also the erased value
    localparam obj_color_t TRANSPARENT = 4'hF;

    // Byte order of one object table entry
    localparam logic [1:0] BYTE_CODE = 2'd0;
    localparam logic [1:0] BYTE_ATTR = 2'd1;
    localparam logic [1:0] BYTE_Y    = 2'd2;
    localparam logic [1:0] BYTE_X    = 2'd3;

    // Attribute byte fields
    localparam int ATTR_CODE_HI = 7;   // Code bits 9:8
    localparam int ATTR_CODE_LO = 6;
    localparam int ATTR_PAL_HI  = 5;
    localparam int ATTR_PAL_LO  = 4;
    localparam int ATTR_VFLIP   = 3;
    localparam int ATTR_HFLIP   = 2;
    localparam int ATTR_XHI     = 0;   // X bit 8

endpackage

//--- logic/obj_scan_if.sv
/*
 * Table walk bus from the object scanner to the object drawer
 * Step count, table byte, object active and walk done flags
 */

interface obj_scan_if import obj_pkg::*; ();

    obj_step_t step;       // Pixel step of the current object
    obj_byte_t buf_data;   // Table byte selected by step[1:0]
    logic      active;     // An object is being walked
    logic      draw_over;  // All objects walked

    modport scan (
        output step,
        output buf_data,
        output active,
        output draw_over
    );

    modport draw (
        input step,
        input buf_data,
        input active,
        input draw_over
    );

endinterface

//--- logic/obj_scan.sv
/*
 * Object table RAM and per-line walk
 * Step and object counters, idle/walk/flush FSM, busy and line_done
 */

module obj_scan import obj_pkg::*; #(
    parameter int OBJ_COUNT = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           tbl_we,
    input  logic [$clog2(OBJ_COUNT)+1:0]   tbl_addr,
    input  obj_byte_t                      tbl_data,
    input  logic                           start_line,
    input  logic                           rom_wait,
    output logic                           busy,
    output logic                           line_done,
    obj_scan_if.scan                       scan
);

    localparam int OBJ_AW = $clog2(OBJ_COUNT);
    localparam int TBL_AW = OBJ_AW + 2;

    typedef enum logic [1:0] {ST_IDLE, ST_WALK, ST_FLUSH} state_t;

    state_t             state;
    obj_byte_t          tbl_ram [OBJ_COUNT*4];
    obj_byte_t          buf_q;
    obj_step_t          step;
    obj_step_t          next_step;
    logic [OBJ_AW-1:0]  obj_idx;
    logic [OBJ_AW-1:0]  next_idx;
    logic [TBL_AW-1:0]  rd_addr;
    logic               adv;
    logic               last_obj;

    assign adv       = cen && !rom_wait && (state != ST_IDLE);
    assign last_obj  = (obj_idx == OBJ_AW'(OBJ_COUNT - 1));
    assign next_step = step + 4'd1;
    assign next_idx  = (step == 4'hF) ? obj_idx + OBJ_AW'(1) : obj_idx;
    // Fetch ahead so the byte sits on the bus during its own step
    assign rd_addr   = (state == ST_IDLE) ? '0 : {next_idx, next_step[1:0]};

    always_ff @(posedge clk) begin
        if (tbl_we) tbl_ram[tbl_addr] <= tbl_data;   // CPU side, any cycle
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE && start_line) || adv) begin
            buf_q <= tbl_ram[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            step      <= '0;
            obj_idx   <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                ST_IDLE: if (start_line) begin
                    state   <= ST_WALK;
                    step    <= '0;
                    obj_idx <= '0;
                end
                ST_WALK: if (adv) begin
                    step    <= next_step;
                    obj_idx <= next_idx;
                    if (step == 4'hF && last_obj) state <= ST_FLUSH;   // Step wraps to 0
                end
                ST_FLUSH: if (adv) begin
                    // Eight more steps drain the last object's pixels
                    if (step == 4'd7) begin
                        state     <= ST_IDLE;
                        step      <= '0;
                        line_done <= 1'b1;
                    end else begin
                        step <= next_step;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy           = (state != ST_IDLE);
    assign scan.step      = step;
    assign scan.buf_data  = buf_q;
    assign scan.active    = (state == ST_WALK);
    assign scan.draw_over = (state != ST_WALK);

endmodule

//--- logic/obj_draw.sv
/*
 * Object drawer
 * Attribute decode, vertical zone check, tile ROM addressing
 * and planar pixel unpacking with horizontal flip
 */

module obj_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  obj_line_t   vline,
    obj_scan_if.draw    scan,
    output rom_addr_t   rom_addr,
    input  rom_word_t   rom_data,
    input  logic        rom_wait,
    output obj_pos_t    pix_x,
    output obj_color_t  pix_color,
    output obj_pal_t    pix_pal
);

    logic        adv;
    obj_code_t   code;
    obj_pal_t    pal;
    logic        vflip;
    logic        hflip;
    logic        x_hi;
    obj_line_t   vdiff;
    obj_row_t    row;
    logic        in_zone;
    obj_pos_t    objx;
    logic [1:0]  col_grp;
    logic [3:0]  plane_z;
    logic [3:0]  plane_y;
    logic [3:0]  plane_x;
    logic [3:0]  plane_w;
    obj_pos_t    posx;
    obj_pal_t    pos_pal;
    logic        pos_hflip;

    assign adv     = cen && !rom_wait;   // Whole path freezes on a ROM stall
    assign vdiff   = vline - scan.buf_data;
    assign col_grp = scan.step[3:2] ^ {2{hflip}};

    // Table bytes arrive one per step during steps 0 to 3
    always_ff @(posedge clk) begin
        if (adv && scan.step[3:2] == 2'd0) begin
            case (scan.step[1:0])
                BYTE_CODE: code[7:0] <= scan.buf_data;
                BYTE_ATTR: begin
                    code[9:8] <= scan.buf_data[ATTR_CODE_HI:ATTR_CODE_LO];
                    pal       <= scan.buf_data[ATTR_PAL_HI:ATTR_PAL_LO];
                    vflip     <= scan.buf_data[ATTR_VFLIP];
                    hflip     <= scan.buf_data[ATTR_HFLIP];
                    x_hi      <= scan.buf_data[ATTR_XHI];
                end
                BYTE_Y: row <= vdiff[3:0] ^ {4{vflip}};
                BYTE_X: objx <= in_zone ? {x_hi, scan.buf_data} : 9'h100;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_zone <= 1'b0;
        end else if (adv && scan.step == {2'b00, BYTE_Y}) begin
            in_zone <= (vdiff < 8'd16);
        end
    end

    // One address per column group, at steps 3, 7, 11 and 15
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_addr <= '0;
        end else if (adv && scan.active && scan.step[1:0] == 2'd3) begin
            rom_addr <= in_zone ? {code, row, col_grp} : '0;
        end
    end

    // Data of the previous group is taken as the next address goes out
    always_ff @(posedge clk) begin
        if (adv) begin
            if (scan.step[1:0] == 2'd3) begin
                {plane_z, plane_y, plane_x, plane_w} <= rom_data;
            end else if (pos_hflip) begin
                plane_z <= plane_z >> 1;
                plane_y <= plane_y >> 1;
                plane_x <= plane_x >> 1;
                plane_w <= plane_w >> 1;
            end else begin
                plane_z <= plane_z << 1;
                plane_y <= plane_y << 1;
                plane_x <= plane_x << 1;
                plane_w <= plane_w << 1;
            end
        end
    end

    // Unpacking runs one object behind the fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            posx      <= 9'h100;
            pos_pal   <= '0;
            pos_hflip <= 1'b0;
        end else if (adv) begin
            if (scan.step == 4'd7) begin
                posx      <= {objx[8] | scan.draw_over, objx[7:0]};
                pos_pal   <= pal;
                pos_hflip <= hflip;
            end else begin
                // Once past the right edge it stays off screen
                posx <= {posx[8] | (&posx[7:0]), posx[7:0] + 8'd1};
            end
        end
    end

    assign pix_x     = posx;
    assign pix_pal   = pos_pal;
    assign pix_color = pos_hflip ? {plane_w[0], plane_x[0], plane_y[0], plane_z[0]}
                                 : {plane_w[3], plane_x[3], plane_y[3], plane_z[3]};

endmodule

//--- logic/obj_linebuf.sv
/*
 * Double-buffered sprite line memory
 * Two 256-entry banks swapped at line start, transparent pixels
 * skipped, display read erases the entry, walking clear after reset
 */

module obj_linebuf import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        start_line,
    input  obj_pos_t    pix_x,
    input  obj_color_t  pix_color,
    input  obj_pal_t    pix_pal,
    input  logic        rd_en,
    input  obj_line_t   rd_x,
    output obj_color_t  rd_color,
    output obj_pal_t    rd_pal
);

    typedef logic [5:0] entry_t;   // {palette, colour}

    localparam entry_t BLANK = {2'b00, TRANSPARENT};

    entry_t     mem [2][256];
    logic       draw_bank;
    logic       rd_bank;
    logic       clearing;
    obj_line_t  clr_addr;
    logic       draw_we;
    logic       we [2];
    obj_line_t  wr_addr [2];
    entry_t     wr_data [2];

    assign rd_bank = ~draw_bank;
    assign draw_we = cen && !pix_x[8] && (pix_color != TRANSPARENT);

    // Each bank takes one write per cycle, draw or erase
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            if (clearing) begin
                we[b]      = 1'b1;
                wr_addr[b] = clr_addr;
                wr_data[b] = BLANK;
            end else if (b == int'(draw_bank)) begin
                we[b]      = draw_we;
                wr_addr[b] = pix_x[7:0];
                wr_data[b] = {pix_pal, pix_color};
            end else begin
                we[b]      = rd_en;   // Erase behind the display read
                wr_addr[b] = rd_x;
                wr_data[b] = BLANK;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (we[b]) mem[b][wr_addr[b]] <= wr_data[b];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) {rd_pal, rd_color} <= mem[rd_bank][rd_x];   // Old value, before erase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            draw_bank <= 1'b0;
            clearing  <= 1'b1;
            clr_addr  <= '0;
        end else begin
            if (start_line) draw_bank <= ~draw_bank;
            if (clearing) begin
                clr_addr <= clr_addr + 8'd1;
                if (&clr_addr) clearing <= 1'b0;   // Both banks done
            end
        end
    end

endmodule

//--- logic/obj_engine.sv
/*
 * Sprite line renderer top level
 * Object scanner, object drawer and line buffer joined by the
 * table walk bus and the pixel ports
 */

module obj_engine import obj_pkg::*; #(
    parameter int OBJ_COUNT = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    // Object table write
    input  logic                          tbl_we,
    input  logic [$clog2(OBJ_COUNT)+1:0]  tbl_addr,
    input  obj_byte_t                     tbl_data,
    // Line control
    input  logic                          start_line,
    input  obj_line_t                     vline,
    // Tile ROM
    output rom_addr_t                     rom_addr,
    input  rom_word_t                     rom_data,
    input  logic                          rom_wait,
    // Status
    output logic                          busy,
    output logic                          line_done,
    // Display side
    input  logic                          rd_en,
    input  obj_line_t                     rd_x,
    output obj_color_t                    rd_color,
    output obj_pal_t                      rd_pal
);

    obj_pos_t    pix_x;
    obj_color_t  pix_color;
    obj_pal_t    pix_pal;

    obj_scan_if scan_bus ();

    obj_scan #(
        .OBJ_COUNT (OBJ_COUNT)
    ) u_scan (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_data   (tbl_data),
        .start_line (start_line),
        .rom_wait   (rom_wait),
        .busy       (busy),
        .line_done  (line_done),
        .scan       (scan_bus.scan)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .vline     (vline),
        .scan      (scan_bus.draw),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_wait  (rom_wait),
        .pix_x     (pix_x),
        .pix_color (pix_color),
        .pix_pal   (pix_pal)
    );

    obj_linebuf u_linebuf (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .start_line (start_line),
        .pix_x      (pix_x),
        .pix_color  (pix_color),
        .pix_pal    (pix_pal),
        .rd_en      (rd_en),
        .rd_x       (rd_x),
        .rd_color   (rd_color),
        .rd_pal     (rd_pal)
    );

endmodule

//--- verification/obj_ref_model.svh
/*
 * Reference model of one sprite line
 * Paints the expected {palette, colour} for every X from the
 * object table copy, the tile ROM array and the line number
 */

`ifndef OBJ_REF_MODEL_SVH
`define OBJ_REF_MODEL_SVH

// Objects are painted in index order, so a higher index wins
task automatic paint_line(input logic [7:0] line);
    logic [7:0]  code_lo;
    logic [7:0]  attr;
    logic [7:0]  diff;
    logic [3:0]  row;
    logic [15:0] word;
    logic [3:0]  color;
    int          q;
    int          b;
    int          x;
    for (int i = 0; i < 256; i++) begin
        exp_entry[i] = BLANK_ENTRY;
    end
    for (int n = 0; n < OBJ_COUNT; n++) begin
        code_lo = tbl[4*n];
        attr    = tbl[4*n+1];
        diff    = line - tbl[4*n+2];
        if (diff < 8'd16) begin
            row = attr[3] ? ~diff[3:0] : diff[3:0];   // vflip
            for (int i = 0; i < 16; i++) begin
                q     = attr[2] ? 15 - i : i;          // hflip mirrors the tile
                word  = rom[{attr[7:6], code_lo, row, 2'(q / 4)}];
                b     = 3 - q % 4;                     // Leftmost pixel is the nibble MSB
                color = {word[b], word[4+b], word[8+b], word[12+b]};   // w, x, y, z
                x     = int'({attr[0], tbl[4*n+3]}) + i;
                // Off the right edge or colour 15 leaves the entry alone
                if (x < 256 && color != 4'hF) begin
                    exp_entry[x] = {attr[5:4], color};
                end
            end
        end
    end
endtask

`endif

//--- verification/obj_tb.sv
/*
 * Testbench for the sprite line renderer
 * Clock, alternate-cycle enable, tile ROM model with random waits,
 * object table stimulus and line readout against the reference model
 */

module obj_tb;

    localparam int OBJ_COUNT    = 32;
    localparam int TBL_AW       = $clog2(OBJ_COUNT) + 2;
    localparam int SEED         = 56268;
    localparam int LINE_TIMEOUT = 20000;
    localparam logic [5:0] BLANK_ENTRY = 6'h0F;   // Palette 0, colour 15

    logic              clk        = 1'b0;
    logic              rst        = 1'b1;
    logic              cen        = 1'b0;
    logic              tbl_we     = 1'b0;
    logic [TBL_AW-1:0] tbl_addr   = '0;
    logic [7:0]        tbl_data   = '0;
    logic              start_line = 1'b0;
    logic [7:0]        vline      = '0;
    logic [15:0]       rom_addr;
    logic [15:0]       rom_data   = '0;
    logic              rom_wait   = 1'b0;
    logic              busy;
    logic              line_done;
    logic              rd_en      = 1'b0;
    logic [7:0]        rd_x       = '0;
    logic [3:0]        rd_color;
    logic [1:0]        rd_pal;

    logic [15:0] rom [65536];
    logic [7:0]  tbl [OBJ_COUNT*4];   // Copy of the DUT object table
    logic [5:0]  exp_entry [256];     // Line being drawn
    logic [5:0]  shown_entry [256];   // Line in the display bank
    string       cur_name      = "reset";
    int          lines_started = 0;
    int          done_pulses   = 0;

    `include "obj_ref_model.svh"

    obj_engine #(
        .OBJ_COUNT (OBJ_COUNT)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_data   (tbl_data),
        .start_line (start_line),
        .vline      (vline),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_wait   (rom_wait),
        .busy       (busy),
        .line_done  (line_done),
        .rd_en      (rd_en),
        .rd_x       (rd_x),
        .rd_color   (rd_color),
        .rd_pal     (rd_pal)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped at the first failure");
    endtask

    task automatic check_entry(input string test, input int x, input logic [5:0] want,
                               input logic [5:0] got);
        assert (got === want) else begin
            $display("ERR %s x=%0d expected %h actual %h", test, x, want, got);
            abort_run();
        end
    endtask

    // attr_lo is {palette, vflip, hflip, unused, X bit 8}
    task automatic write_obj(input int idx, input logic [9:0] code, input logic [5:0] attr_lo,
                             input logic [7:0] ypos, input logic [7:0] xpos);
        logic [7:0] bytes [4];
        bytes = '{code[7:0], {code[9:8], attr_lo}, ypos, xpos};
        for (int k = 0; k < 4; k++) begin
            tbl[4*idx+k] = bytes[k];
            tbl_we       = 1'b1;
            tbl_addr     = TBL_AW'(4*idx + k);
            tbl_data     = bytes[k];
            @(negedge clk);
        end
        tbl_we = 1'b0;
    endtask

    // Far above every tested line and off the right edge
    task automatic park_table();
        for (int n = 0; n < OBJ_COUNT; n++) begin
            write_obj(n, 10'h000, 6'h01, 8'hC0, 8'h00);
        end
    endtask

    task automatic pulse_start();
        assert (!busy) else begin
            $display("start_line requested while the previous line was still busy");
            abort_run();
        end
        start_line = 1'b1;
        lines_started++;
        @(negedge clk);
        start_line = 1'b0;
        assert (busy) else begin
            $display("busy did not rise in the cycle after start_line");
            abort_run();
        end
    endtask

    // Pipelined read where each result lands one clock after its address
    task automatic read_bank(input string test, input bit erased);
        for (int i = 0; i <= 256; i++) begin
            rd_en = (i < 256);
            rd_x  = 8'(i);
            if (i > 0) begin
                check_entry(test, i - 1, erased ? BLANK_ENTRY : shown_entry[i-1],
                            {rd_pal, rd_color});
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!line_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > LINE_TIMEOUT) begin
                $display("Timeout: no line_done within %0d cycles", LINE_TIMEOUT);
                abort_run();
            end
        end
        @(negedge clk);
        @(negedge clk);
        assert (done_pulses == lines_started && !line_done) else begin
            $display("ERR line_done_pulse expected %0d actual %0d", lines_started, done_pulses);
            abort_run();
        end
    endtask

    // Starts a line from the current table and reads back the one before it
    task automatic next_line(input string test, input logic [7:0] line);
        string prev_name;
        prev_name   = cur_name;
        cur_name    = test;
        shown_entry = exp_entry;
        paint_line(line);
        vline = line;
        pulse_start();
        read_bank(prev_name, 1'b0);
        read_bank({prev_name, "_erased"}, 1'b1);
        wait_done();
    endtask

    // Enable on every other cycle and ROM waits only while it is high
    always @(negedge clk) begin
        cen      = ~cen;
        rom_wait = cen && ($urandom_range(0, 3) == 0);
        rom_data = rom[rom_addr];   // Ready by the next rising edge
    end

    always @(negedge clk) begin
        if (line_done) begin
            done_pulses++;
            assert (!busy) else begin
                $display("line_done pulsed while busy was still high");
                abort_run();
            end
        end
    end

    initial begin
        logic [7:0] ln;
        void'($urandom(SEED));
        for (int a = 0; a < 65536; a++) begin
            rom[a] = 16'($urandom);
        end
        // Tile 2A5 has group 1 fully clear and two clear pixels in each other group
        for (int a = 0; a < 64; a++) begin
            rom[{10'h2A5, 6'(a)}] = (a % 4 == 1) ? 16'hFFFF : (16'($urandom) | 16'hCCCC);
        end
        for (int i = 0; i < 256; i++) begin
            exp_entry[i] = BLANK_ENTRY;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (!busy && !line_done) else begin
            $display("busy or line_done high after reset");
            abort_run();
        end
        assert (rom_addr == 16'h0000) else begin
            $display("ERR reset rom_addr expected %h actual %h", 16'h0000, rom_addr);
            abort_run();
        end
        repeat (260) @(negedge clk);   // Line buffer clear walk
        park_table();
        write_obj(3, 10'h112, 6'h20, 8'd95, 8'd40);
        next_line("single", 8'd100);
        write_obj(3, 10'h112, 6'h24, 8'd95, 8'd40);
        next_line("hflip", 8'd100);
        write_obj(3, 10'h112, 6'h28, 8'd95, 8'd40);
        next_line("vflip", 8'd100);
        write_obj(3, 10'h112, 6'h00, 8'd101, 8'd10);    // Line is one row above
        write_obj(4, 10'h0A7, 6'h10, 8'd84, 8'd30);     // Sixteen rows below
        write_obj(5, 10'h0A8, 6'h10, 8'd85, 8'd60);     // Last row in zone
        write_obj(6, 10'h0A9, 6'h30, 8'd100, 8'd250);   // Clipped at X 256
        write_obj(7, 10'h0AA, 6'h01, 8'd92, 8'd20);
        next_line("clip", 8'd100);
        park_table();
        write_obj(2, 10'h155, 6'h10, 8'd30, 8'd60);
        write_obj(9, 10'h2A5, 6'h34, 8'd33, 8'd66);
        write_obj(20, 10'h2A5, 6'h20, 8'd40, 8'd70);
        next_line("overlap", 8'd40);
        for (int l = 0; l < 4; l++) begin
            ln = 8'($urandom);
            for (int n = 0; n < OBJ_COUNT; n++) begin
                write_obj(n, 10'($urandom),
                          {2'($urandom), 2'($urandom), 1'b0, $urandom_range(0, 7) == 0},
                          ln - 8'($urandom_range(0, 23)), 8'($urandom));
            end
            next_line($sformatf("random%0d", l), ln);
        end
        park_table();
        next_line("flush", 8'd0);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+verification
logic/obj_pkg.sv
logic/obj_scan_if.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_linebuf.sv
logic/obj_engine.sv
verification/obj_tb.sv

//--- Makefile
# Verilator simulation of the sprite line renderer
TOP := obj_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass decided from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
